// File: verilog/line_trace_pkg.sv
package line_trace_pkg;

	// --------------------------------------------------
	// cache geometry
	// --------------------------------------------------

	// number of tracked lines, fixed so the structs keep a fixed width
	localparam int LINE_COUNT = 16;
	localparam int LINE_BITS  = $clog2(LINE_COUNT);

	// ages are 8 bits and saturate here
	localparam logic [7:0] AGE_MAX = 8'd255;

	// --------------------------------------------------
	// bundled signals
	// --------------------------------------------------

	// one cache access as seen from the controller
	typedef struct packed {
		logic                 valid;
		logic [LINE_BITS-1:0] line;
	} line_request_t;

	// host side configuration levels
	typedef struct packed {
		logic       enable;
		logic       clear;
		logic [7:0] threshold_0;
		logic [7:0] threshold_1;
		logic [7:0] threshold_2;
	} trace_cfg_t;

	// one expired bit per line for each threshold
	typedef struct packed {
		logic [LINE_COUNT-1:0] expired_0;
		logic [LINE_COUNT-1:0] expired_1;
		logic [LINE_COUNT-1:0] expired_2;
	} expiry_set_t;

	// what a single sample leaves in the buffer
	typedef struct packed {
		expiry_set_t expiry;
		logic [31:0] trace_count;
	} trace_entry_t;

	// scheduler FSM
	typedef enum logic [1:0] {
		SCHED_IDLE,
		SCHED_TRACK,
		SCHED_FULL
	} sched_state_e;

endpackage

// File: verilog/trace_memory.sv
`timescale 1ns/1ps

module trace_memory #(
	parameter int DEPTH = 4096,
	parameter int WIDTH = 32
) (
	input  logic                     clock_i,
	input  logic                     write_i,
	input  logic [$clog2(DEPTH)-1:0] addr_i,
	input  logic [WIDTH-1:0]         data_i,
	output logic [WIDTH-1:0]         data_o
);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------

	logic [WIDTH-1:0] mem_q [DEPTH];

	// single port, read-first on a write
	always_ff @(posedge clock_i) begin
		if (write_i) begin
			mem_q[addr_i] <= data_i;
		end
		// read data registered, valid the cycle after the address
		data_o <= mem_q[addr_i];
	end

endmodule

// File: verilog/line_age_tracker.sv
`timescale 1ns/1ps

module line_age_tracker (
	input  logic                          clock_i,
	input  logic                          resetn_i,
	input  line_trace_pkg::line_request_t request_i,
	input  logic                          active_i,
	input  line_trace_pkg::trace_cfg_t    cfg_i,
	output line_trace_pkg::expiry_set_t   expiry_o
);
	import line_trace_pkg::*;

	// --------------------------------------------------
	// per line ages
	// --------------------------------------------------

	// age 0 means just touched, AGE_MAX means long idle or never seen
	logic [7:0] age_q [LINE_COUNT];
	logic       accept;

	// requests only count while the scheduler is tracking
	assign accept = request_i.valid && active_i;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			// everything starts out as old as possible
			for (int i = 0; i < LINE_COUNT; i++) begin
				age_q[i] <= AGE_MAX;
			end
		end else if (accept) begin
			for (int i = 0; i < LINE_COUNT; i++) begin
				if (request_i.line == LINE_BITS'(i)) begin
					// accessed line restarts its age
					age_q[i] <= 8'd0;
				end else if (age_q[i] != AGE_MAX) begin
					// all others grow older, saturating
					age_q[i] <= age_q[i] + 8'd1;
				end
			end
		end
	end

	// --------------------------------------------------
	// threshold compare
	// --------------------------------------------------

	// purely combinational from the registered ages
	always_comb begin
		expiry_o = '0;
		for (int i = 0; i < LINE_COUNT; i++) begin
			// strictly greater than, so a threshold of 0 flags any line not hit last
			expiry_o.expired_0[i] = age_q[i] > cfg_i.threshold_0;
			expiry_o.expired_1[i] = age_q[i] > cfg_i.threshold_1;
			expiry_o.expired_2[i] = age_q[i] > cfg_i.threshold_2;
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	for (genvar g = 0; g < LINE_COUNT; g++) begin : g_age_check
		// a saturated age stays put until its own line is accessed
		// so an age can never wrap past AGE_MAX
		a_age_saturates: assert property (
			@(posedge clock_i) disable iff (!resetn_i)
			(age_q[g] == AGE_MAX) && !(accept && (request_i.line == LINE_BITS'(g)))
			|=> (age_q[g] == AGE_MAX)
		);
	end

endmodule

// File: verilog/sample_scheduler.sv
`timescale 1ns/1ps

module sample_scheduler #(
	parameter int SAMPLE_PERIOD = 4,
	parameter int BUFFER_DEPTH  = 4096
) (
	input  logic                            clock_i,
	input  logic                            resetn_i,
	input  line_trace_pkg::line_request_t   request_i,
	input  line_trace_pkg::trace_cfg_t      cfg_i,
	output logic                            active_o,
	output logic                            stall_o,
	output logic [31:0]                     count_o,
	output logic                            sample_o,
	output logic [31:0]                     sample_count_o,
	output logic [$clog2(BUFFER_DEPTH)-1:0] write_addr_o,
	output logic                            host_access_o
);
	import line_trace_pkg::*;

	localparam int ADDR_BITS   = $clog2(BUFFER_DEPTH);
	localparam int PERIOD_BITS = $clog2(SAMPLE_PERIOD + 1);

	sched_state_e           state_q;
	sched_state_e           state_d;
	logic [PERIOD_BITS-1:0] period_q;
	logic [31:0]            request_count_q;
	logic [ADDR_BITS:0]     fill_q;
	logic [ADDR_BITS-1:0]   next_addr_q;
	logic                   sample_q;
	logic [31:0]            sample_count_q;
	logic [ADDR_BITS-1:0]   write_addr_q;
	logic                   accept;
	logic                   last_write;
	logic                   trigger;

	// --------------------------------------------------
	// request qualification
	// --------------------------------------------------

	assign stall_o  = (state_q == SCHED_FULL);
	assign active_o = cfg_i.enable && !stall_o;
	assign accept   = request_i.valid && active_o;

	// the write going out now fills the last entry
	assign last_write = sample_q && (write_addr_q == ADDR_BITS'(BUFFER_DEPTH - 1));

	// period expires on this request; no new sample behind the final one
	assign trigger = accept && (period_q == PERIOD_BITS'(1)) && !last_write;

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			SCHED_IDLE: begin
				if (cfg_i.enable) begin
					state_d = SCHED_TRACK;
				end
			end
			SCHED_TRACK: begin
				// leave tracking only once a pending write is out
				if (last_write) begin
					state_d = SCHED_FULL;
				end else if (!cfg_i.enable && !sample_q) begin
					state_d = SCHED_IDLE;
				end
			end
			SCHED_FULL: begin
				// held until the host clears
				state_d = SCHED_FULL;
			end
			default: begin
				state_d = SCHED_IDLE;
			end
		endcase
		if (cfg_i.clear) begin
			state_d = cfg_i.enable ? SCHED_TRACK : SCHED_IDLE;
		end
	end

	// --------------------------------------------------
	// counters
	// --------------------------------------------------

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q         <= SCHED_IDLE;
			period_q        <= PERIOD_BITS'(SAMPLE_PERIOD);
			request_count_q <= '0;
			fill_q          <= '0;
			next_addr_q     <= '0;
			sample_q        <= 1'b0;
		end else begin
			state_q  <= state_d;
			sample_q <= trigger && !cfg_i.clear;
			if (cfg_i.clear) begin
				// clear restarts the trace from scratch, ages excepted
				period_q        <= PERIOD_BITS'(SAMPLE_PERIOD);
				request_count_q <= '0;
				fill_q          <= '0;
				next_addr_q     <= '0;
			end else begin
				if (accept) begin
					request_count_q <= request_count_q + 32'd1;
					if (period_q == PERIOD_BITS'(1)) begin
						period_q <= PERIOD_BITS'(SAMPLE_PERIOD);
					end else begin
						period_q <= period_q - PERIOD_BITS'(1);
					end
				end
				// address is claimed when the sample is scheduled
				if (trigger) begin
					next_addr_q <= next_addr_q + ADDR_BITS'(1);
				end
				// fill level follows the actual write
				if (sample_q) begin
					fill_q <= fill_q + (ADDR_BITS + 1)'(1);
				end
			end
		end
	end

	// count before the sampled request, and where it goes
	always_ff @(posedge clock_i) begin
		if (trigger) begin
			sample_count_q <= request_count_q;
			write_addr_q   <= next_addr_q;
		end
	end

	assign sample_o       = sample_q;
	assign sample_count_o = sample_count_q;
	assign write_addr_o   = write_addr_q;
	assign count_o        = 32'(fill_q);

	// host owns the buffer whenever the FSM is not tracking
	// lags enable by a cycle so an in-flight write lands first
	assign host_access_o = (state_q != SCHED_TRACK);

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	a_no_sample_full: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		(state_q == SCHED_FULL) |-> !sample_o
	);

	a_fill_bound: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		count_o <= 32'(BUFFER_DEPTH)
	);

endmodule

// File: verilog/trace_buffer.sv
`timescale 1ns/1ps

module trace_buffer #(
	parameter int BUFFER_DEPTH = 4096
) (
	input  logic                            clock_i,
	input  logic                            resetn_i,
	input  line_trace_pkg::expiry_set_t     expiry_i,
	input  logic                            sample_i,
	input  logic [31:0]                     sample_count_i,
	input  logic [$clog2(BUFFER_DEPTH)-1:0] write_addr_i,
	input  logic                            host_access_i,
	input  logic [$clog2(BUFFER_DEPTH)-1:0] read_addr_i,
	output line_trace_pkg::trace_entry_t    read_entry_o
);
	import line_trace_pkg::*;

	localparam int ADDR_BITS = $clog2(BUFFER_DEPTH);

	expiry_set_t           expiry_q;
	trace_entry_t          write_entry;
	trace_entry_t          ram_entry;
	trace_entry_t          held_entry_q;
	logic [ADDR_BITS-1:0]  read_addr_q;
	logic [ADDR_BITS-1:0]  mem_addr;
	logic                  read_pending_q;
	logic                  read_valid_q;
	logic [LINE_COUNT-1:0] ram_expired_0;
	logic [LINE_COUNT-1:0] ram_expired_1;
	logic [LINE_COUNT-1:0] ram_expired_2;
	logic [31:0]           ram_count;

	// --------------------------------------------------
	// sample capture
	// --------------------------------------------------

	// one cycle behind the tracker, so at the sample strobe this holds
	// the bits from before the sampled request's own age update
	always_ff @(posedge clock_i) begin
		expiry_q <= expiry_i;
	end

	assign write_entry.expiry      = expiry_q;
	assign write_entry.trace_count = sample_count_i;

	// --------------------------------------------------
	// address arbitration
	// --------------------------------------------------

	// host address is registered first, then the RAM registers its data
	always_ff @(posedge clock_i) begin
		if (host_access_i) begin
			read_addr_q <= read_addr_i;
		end
	end

	// sample writes take the port, otherwise the host address
	assign mem_addr = sample_i ? write_addr_i : read_addr_q;

	// tracks which RAM outputs really belong to a host read
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			read_pending_q <= 1'b0;
			read_valid_q   <= 1'b0;
		end else begin
			read_pending_q <= host_access_i;
			read_valid_q   <= read_pending_q && !sample_i;
		end
	end

	// --------------------------------------------------
	// memories
	// --------------------------------------------------

	trace_memory #(.DEPTH(BUFFER_DEPTH), .WIDTH(LINE_COUNT)) u_expired_0_mem (
		.clock_i (clock_i),
		.write_i (sample_i),
		.addr_i  (mem_addr),
		.data_i  (write_entry.expiry.expired_0),
		.data_o  (ram_expired_0)
	);

	trace_memory #(.DEPTH(BUFFER_DEPTH), .WIDTH(LINE_COUNT)) u_expired_1_mem (
		.clock_i (clock_i),
		.write_i (sample_i),
		.addr_i  (mem_addr),
		.data_i  (write_entry.expiry.expired_1),
		.data_o  (ram_expired_1)
	);

	trace_memory #(.DEPTH(BUFFER_DEPTH), .WIDTH(LINE_COUNT)) u_expired_2_mem (
		.clock_i (clock_i),
		.write_i (sample_i),
		.addr_i  (mem_addr),
		.data_i  (write_entry.expiry.expired_2),
		.data_o  (ram_expired_2)
	);

	trace_memory #(.DEPTH(BUFFER_DEPTH), .WIDTH(32)) u_count_mem (
		.clock_i (clock_i),
		.write_i (sample_i),
		.addr_i  (mem_addr),
		.data_i  (write_entry.trace_count),
		.data_o  (ram_count)
	);

	// --------------------------------------------------
	// read side
	// --------------------------------------------------

	assign ram_entry = '{
		expiry:      '{expired_0: ram_expired_0, expired_1: ram_expired_1,
		               expired_2: ram_expired_2},
		trace_count: ram_count
	};

	// last good read is kept while the host is locked out
	always_ff @(posedge clock_i) begin
		if (read_valid_q) begin
			held_entry_q <= ram_entry;
		end
	end

	assign read_entry_o = read_valid_q ? ram_entry : held_entry_q;

	// scheduler must never hand the host the port during a write
	a_port_exclusive: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		!(sample_i && host_access_i)
	);

endmodule

// File: verilog/line_trace_top.sv
`timescale 1ns/1ps

module line_trace_top #(
	parameter int SAMPLE_PERIOD = 4,
	parameter int BUFFER_DEPTH  = 4096
) (
	input  logic                            clock_i,
	input  logic                            resetn_i,
	input  line_trace_pkg::line_request_t   request_i,
	input  line_trace_pkg::trace_cfg_t      cfg_i,
	input  logic [$clog2(BUFFER_DEPTH)-1:0] read_addr_i,
	output logic                            stall_o,
	output logic [31:0]                     count_o,
	output line_trace_pkg::trace_entry_t    read_entry_o,
	output line_trace_pkg::expiry_set_t     expiry_o
);

	localparam int ADDR_BITS = $clog2(BUFFER_DEPTH);

	// --------------------------------------------------
	// scheduler to tracker and buffer
	// --------------------------------------------------

	logic                 active;
	logic                 sample;
	logic [31:0]          sample_count;
	logic [ADDR_BITS-1:0] write_addr;
	logic                 host_access;

	// ages and expired bits, also visible live at the top
	line_age_tracker u_line_age_tracker (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.request_i(request_i),
		.active_i (active),
		.cfg_i    (cfg_i),
		.expiry_o (expiry_o)
	);

	// request counting, sample timing, fill and stall
	sample_scheduler #(
		.SAMPLE_PERIOD(SAMPLE_PERIOD),
		.BUFFER_DEPTH (BUFFER_DEPTH)
	) u_sample_scheduler (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.request_i     (request_i),
		.cfg_i         (cfg_i),
		.active_o      (active),
		.stall_o       (stall_o),
		.count_o       (count_o),
		.sample_o      (sample),
		.sample_count_o(sample_count),
		.write_addr_o  (write_addr),
		.host_access_o (host_access)
	);

	// sample storage and host readback
	trace_buffer #(
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) u_trace_buffer (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.expiry_i      (expiry_o),
		.sample_i      (sample),
		.sample_count_i(sample_count),
		.write_addr_i  (write_addr),
		.host_access_i (host_access),
		.read_addr_i   (read_addr_i),
		.read_entry_o  (read_entry_o)
	);

endmodule

// File: bench/line_trace_tb.sv
`timescale 1ns/1ps

module line_trace_tb;
	import line_trace_pkg::*;

	localparam int    SAMPLE_PERIOD   = 4;
	localparam int    BUFFER_DEPTH    = 8;
	localparam int    ADDR_BITS       = $clog2(BUFFER_DEPTH);
	localparam int    RESET_CYCLES    = 16;
	localparam int    CYCLES_PER_LINE = 200;
	localparam string GOLDEN_FILE     = "bench/line_trace_golden.txt";

	logic                 clock;
	logic                 resetn;
	line_request_t        request;
	trace_cfg_t           cfg;
	logic [ADDR_BITS-1:0] read_addr;
	logic                 stall;
	logic [31:0]          count;
	trace_entry_t         read_entry;
	expiry_set_t          expiry;

	// golden file reader state
	int               fd;
	int               n;
	int               line_no;
	int               line_count;
	int               watchdog_cycles;
	logic             done;
	logic [63:0]      op;
	logic [8*160-1:0] line_buf;
	logic [31:0]      f0;
	logic [31:0]      f1;
	logic [31:0]      f2;
	logic [31:0]      f3;
	logic [31:0]      f4;

	line_trace_top #(
		.SAMPLE_PERIOD(SAMPLE_PERIOD),
		.BUFFER_DEPTH (BUFFER_DEPTH)
	) u_line_trace_top (
		.clock_i     (clock),
		.resetn_i    (resetn),
		.request_i   (request),
		.cfg_i       (cfg),
		.read_addr_i (read_addr),
		.stall_o     (stall),
		.count_o     (count),
		.read_entry_o(read_entry),
		.expiry_o    (expiry)
	);

	// 40 ns clock
	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	// --------------------------------------------------
	// reporting
	// --------------------------------------------------

	task automatic fail_run(input string reason);
		$display("%0s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("MISMATCH %0s expected 0x%08h actual 0x%08h",
				name, expected, actual));
		end
	endtask

	task automatic expect_fields(input int got, input int want);
		if (got != want) begin
			fail_run($sformatf("golden line %0d has %0d fields, %0d needed", line_no, got, want));
		end
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------

	// one cycle pulse, then at least one idle cycle so no request
	// lands in the cycle of a pending buffer write
	task automatic apply_request(input logic [LINE_BITS-1:0] line);
		int gap;
		gap = $urandom_range(3, 1);
		@(posedge clock);
		request <= '{valid: 1'b1, line: line};
		@(posedge clock);
		request.valid <= 1'b0;
		repeat (gap) @(posedge clock);
	endtask

	task automatic apply_config(input logic enable, input logic [7:0] t0,
			input logic [7:0] t1, input logic [7:0] t2);
		@(posedge clock);
		cfg.enable      <= enable;
		cfg.threshold_0 <= t0;
		cfg.threshold_1 <= t1;
		cfg.threshold_2 <= t2;
		// let the FSM settle into its new state
		repeat (3) @(posedge clock);
	endtask

	task automatic pulse_clear();
		@(posedge clock);
		cfg.clear <= 1'b1;
		@(posedge clock);
		cfg.clear <= 1'b0;
		repeat (2) @(posedge clock);
	endtask

	// status and live expired bits, sampled away from the clock edge
	task automatic check_status(input logic [31:0] exp_stall, input logic [31:0] exp_count,
			input logic [31:0] e0, input logic [31:0] e1, input logic [31:0] e2);
		@(negedge clock);
		check_value($sformatf("line %0d stall", line_no), exp_stall, 32'(stall));
		check_value($sformatf("line %0d count", line_no), exp_count, count);
		check_value($sformatf("line %0d expired_0", line_no), e0, 32'(expiry.expired_0));
		check_value($sformatf("line %0d expired_1", line_no), e1, 32'(expiry.expired_1));
		check_value($sformatf("line %0d expired_2", line_no), e2, 32'(expiry.expired_2));
	endtask

	task automatic check_entry(input logic [ADDR_BITS-1:0] addr, input logic [31:0] exp_count,
			input logic [31:0] e0, input logic [31:0] e1, input logic [31:0] e2);
		@(posedge clock);
		read_addr <= addr;
		// address register then RAM output register
		repeat (2) @(posedge clock);
		@(negedge clock);
		check_value($sformatf("line %0d trace_count", line_no), exp_count,
			read_entry.trace_count);
		check_value($sformatf("line %0d entry expired_0", line_no), e0,
			32'(read_entry.expiry.expired_0));
		check_value($sformatf("line %0d entry expired_1", line_no), e1,
			32'(read_entry.expiry.expired_1));
		check_value($sformatf("line %0d entry expired_2", line_no), e2,
			32'(read_entry.expiry.expired_2));
	endtask

	// one golden line, opcode already read into op
	task automatic run_operation();
		case (op)
			64'("#"): begin
				void'($fgets(line_buf, fd));
			end
			64'("REQ"): begin
				n = $fscanf(fd, "%h", f0);
				expect_fields(n, 1);
				apply_request(f0[LINE_BITS-1:0]);
			end
			64'("CFG"): begin
				n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
				expect_fields(n, 4);
				apply_config(f0[0], f1[7:0], f2[7:0], f3[7:0]);
			end
			64'("CLR"): begin
				pulse_clear();
			end
			64'("CHECK"): begin
				n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
				expect_fields(n, 5);
				check_status(f0, f1, f2, f3, f4);
			end
			64'("READ"): begin
				n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
				expect_fields(n, 5);
				check_entry(f0[ADDR_BITS-1:0], f1, f2, f3, f4);
			end
			default: begin
				fail_run($sformatf("unknown opcode on golden line %0d", line_no));
			end
		endcase
	endtask

	// --------------------------------------------------
	// watchdog
	// --------------------------------------------------

	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		fail_run($sformatf("simulation timed out after %0d cycles", watchdog_cycles));
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------

	initial begin
		void'($urandom(26606));
		resetn          = 1'b0;
		request         = '0;
		cfg             = '0;
		read_addr       = '0;
		line_no         = 0;
		line_count      = 0;
		watchdog_cycles = 0;
		done            = 1'b0;

		// first pass sizes the watchdog
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			fail_run($sformatf("cannot open %0s", GOLDEN_FILE));
		end
		while ($fgets(line_buf, fd) != 0) begin
			line_count++;
		end
		$fclose(fd);
		watchdog_cycles = line_count * CYCLES_PER_LINE + RESET_CYCLES;

		fd = $fopen(GOLDEN_FILE, "r");
		repeat (RESET_CYCLES) @(posedge clock);
		resetn <= 1'b1;
		@(posedge clock);

		while (!done) begin
			n = $fscanf(fd, "%s", op);
			if (n != 1) begin
				done = 1'b1;
			end else begin
				line_no++;
				run_operation();
			end
		end
		$fclose(fd);

		$display("TEST OK");
		$finish;
	end

endmodule

// File: line_trace.f
verilog/line_trace_pkg.sv
verilog/trace_memory.sv
verilog/line_age_tracker.sv
verilog/sample_scheduler.sv
verilog/trace_buffer.sv
verilog/line_trace_top.sv
bench/line_trace_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, then run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module line_trace_tb -f line_trace.f \
	|| { echo "verilator build failed"; exit 1; }

sim_output=$(./obj_dir/Vline_trace_tb 2>&1)
printf '%s\n' "$sim_output"
printf '%s\n' "$sim_output" | grep -qx "TEST OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: bench/line_trace_golden.txt
# one operation per line, all fields hex
# REQ line | CFG en t0 t1 t2 | CLR | CHECK stall count e0 e1 e2 | READ addr count e0 e1 e2
CFG 1 00 02 05
CHECK 0 00000000 ffff ffff ffff
REQ 0
REQ 1
REQ 2
REQ 3
CHECK 0 00000001 fff7 fff1 fff0
REQ 0
REQ 1
REQ 4
REQ 0
REQ 2
REQ 5
REQ 5
REQ 6
CHECK 0 00000003 ffbf ff9f ff8a
# tracking off, host reads the first three samples
CFG 0 00 02 05
READ 0 00000003 fffb fff8 fff8
READ 1 00000007 ffef ffec ffe0
READ 2 0000000b ffdf ffdb ffc8
REQ 7
REQ 8
CHECK 0 00000003 ffbf ff9f ff8a
# tracking on again until the buffer fills
CFG 1 00 02 05
REQ 7
REQ 8
REQ 9
REQ a
REQ b
REQ c
REQ d
REQ e
REQ f
REQ 0
REQ 3
REQ 3
REQ 9
REQ c
REQ 6
REQ 1
REQ 2
REQ 2
REQ f
REQ 4
CHECK 1 00000008 ffef 7feb 7fa9
REQ 0
REQ 5
CHECK 1 00000008 ffef 7feb 7fa9
READ 0 00000003 fffb fff8 fff8
READ 1 00000007 ffef ffec ffe0
READ 2 0000000b ffdf ffdb ffc8
READ 3 0000000f fdff fc7f fc1f
READ 4 00000013 dfff c7ff c0ff
READ 5 00000017 fff7 7ff6 0ff6
READ 6 0000001b ffbf edbf edb6
READ 7 0000001f 7fff 7ffb 6fb9
# clear keeps the ages, restarts the trace
CLR
CHECK 0 00000000 ffef 7feb 7fa9
REQ 1
REQ 2
REQ 3
REQ 4
CHECK 0 00000001 ffef ffe3 7fe1
CFG 0 00 02 05
READ 0 00000003 fff7 fff1 7fe1
